/* source/mxd_params.svh */
// Macros for symbol lane count, output flow count and symbol width
`ifndef MXD_PARAMS_SVH
`define MXD_PARAMS_SVH

// Symbol lanes the source can offer in one cycle
// The distributor needs at least two lanes to be a multi-transfer design
`define NUM_SYMBOLS 2

// Output flows that the lanes are distributed over
// Must be at least NUM_SYMBOLS so that every lane can find its own flow
`define NUM_FLOWS 4

// Payload bits carried by one symbol
`define SYMBOL_WIDTH 8

`endif

/* source/mxd_pkg.sv */
// Package with the symbol, symbol count, flow mask and flow index types
`default_nettype none

`include "mxd_params.svh"

package mxd_pkg;

  // One symbol of payload on a push lane or a pop flow
  typedef logic [`SYMBOL_WIDTH-1:0] symbol_t;

  // Symbol count from 0 up to NUM_SYMBOLS inclusive
  // Used for sendable, receivable, grant_allowed and grant_count
  typedef logic [$clog2(`NUM_SYMBOLS + 1)-1:0] count_t;

  // One bit per output flow, bit i belongs to flow i
  typedef logic [`NUM_FLOWS-1:0] flow_mask_t;

  // Index of one output flow, also the round-robin starting point
  typedef logic [$clog2(`NUM_FLOWS)-1:0] flow_idx_t;

endpackage

`default_nettype wire

/* source/rr_priority_pointer.sv */
// Round-robin priority pointer that moves past the last granted flow
`default_nettype none

`include "mxd_params.svh"

module rr_priority_pointer (
  input  logic                clk,
  input  logic                arst_n,
  input  mxd_pkg::flow_mask_t grant,
  input  mxd_pkg::count_t     grant_count,
  output mxd_pkg::flow_idx_t  priority_idx
);

  // Candidate starting flow for the next cycle
  mxd_pkg::flow_idx_t priority_next;

  // Walk the flows in the same order the arbiter scans them
  // The last granted flow seen in that walk is the last one served
  always_comb begin
    int flow;
    int last;
    last = int'(priority_idx);
    for (int k = 0; k < `NUM_FLOWS; k++) begin
      flow = (int'(priority_idx) + k) % `NUM_FLOWS;
      if (grant[flow]) begin
        last = flow;
      end
    end
    // The flow right after the last served one starts the next scan
    priority_next = mxd_pkg::flow_idx_t'((last + 1) % `NUM_FLOWS);
  end

  // Pointer register, flow 0 has priority out of reset
  // It only moves in a cycle where at least one symbol was handed out,
  // so idle cycles and fully stalled cycles keep the turn order
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      priority_idx <= '0;
    end else if (grant_count != '0) begin
      priority_idx <= priority_next;
    end
  end

endmodule

`default_nettype wire

/* source/multi_grant_arbiter.sv */
// Multi-grant round-robin arbiter with per-lane ordered grants and a grant count
`default_nettype none

`include "mxd_params.svh"

module multi_grant_arbiter (
  input  mxd_pkg::flow_mask_t request,
  input  mxd_pkg::count_t     grant_allowed,
  input  mxd_pkg::flow_idx_t  priority_idx,
  output mxd_pkg::flow_mask_t grant,
  output mxd_pkg::flow_mask_t grant_ordered [`NUM_SYMBOLS],
  output mxd_pkg::count_t     grant_count
);

  // Scan the flows starting at priority_idx and wrap around once
  // Each requesting flow met in the scan takes the next free lane,
  // until grant_allowed lanes are taken or the scan ends
  // Lane j therefore holds the j-th granted flow in scan order
  always_comb begin
    int filled;
    int flow;
    filled = 0;
    for (int j = 0; j < `NUM_SYMBOLS; j++) begin
      grant_ordered[j] = '0;
    end
    for (int k = 0; k < `NUM_FLOWS; k++) begin
      flow = (int'(priority_idx) + k) % `NUM_FLOWS;
      // The lane limit also guards grant_allowed values above NUM_SYMBOLS
      if (request[flow] && (filled < int'(grant_allowed)) && (filled < `NUM_SYMBOLS)) begin
        grant_ordered[filled][flow] = 1'b1;
        filled = filled + 1;
      end
    end
    // Filled lanes are always a prefix, so their number is the count
    grant_count = mxd_pkg::count_t'(filled);
  end

  // Flat grant mask, each flow appears in at most one lane
  always_comb begin
    grant = '0;
    for (int j = 0; j < `NUM_SYMBOLS; j++) begin
      grant = grant | grant_ordered[j];
    end
  end

endmodule

`default_nettype wire

/* source/multi_xfer_distributor_core.sv */
// Distributor core that maps push and pop ports onto the arbiter and steers lane data
`default_nettype none

`include "mxd_params.svh"

module multi_xfer_distributor_core #(
  parameter type symbol_type = mxd_pkg::symbol_t
) (
  input  mxd_pkg::count_t     push_sendable,
  output mxd_pkg::count_t     push_receivable,
  input  symbol_type          push_data [`NUM_SYMBOLS],
  output mxd_pkg::flow_mask_t pop_valid,
  input  mxd_pkg::flow_mask_t pop_ready,
  output symbol_type          pop_data [`NUM_FLOWS],
  output mxd_pkg::flow_mask_t request,
  output mxd_pkg::count_t     grant_allowed,
  input  mxd_pkg::flow_mask_t grant,
  input  mxd_pkg::flow_mask_t grant_ordered [`NUM_SYMBOLS],
  input  mxd_pkg::count_t     grant_count
);

  // Payload width, taken from whatever type the core carries
  localparam int symbol_bits = $bits(symbol_type);

  // Per flow, which lane it was granted, one-hot or zero
  logic [`NUM_SYMBOLS-1:0] lane_select [`NUM_FLOWS];

  // A ready flow is a requester and every offered symbol may be granted
  assign request       = pop_ready;
  assign grant_allowed = push_sendable;

  // Grants are only given to ready flows, so a grant is a finished transfer
  assign pop_valid = grant;

  // Granted lanes form a prefix, so their count is what the source loses
  assign push_receivable = grant_count;

  for (genvar i = 0; i < `NUM_FLOWS; i++) begin : gen_pop_data
    // Transpose the lane grants into a per-flow lane select
    for (genvar j = 0; j < `NUM_SYMBOLS; j++) begin : gen_lane_select
      assign lane_select[i][j] = grant_ordered[j][i];
    end

    // One-hot mux of the lanes onto this flow
    // With no lane selected the flow outputs zero
    always_comb begin
      logic [symbol_bits-1:0] merged;
      merged = '0;
      for (int j = 0; j < `NUM_SYMBOLS; j++) begin
        merged = merged | ({symbol_bits{lane_select[i][j]}} & symbol_bits'(push_data[j]));
      end
      pop_data[i] = symbol_type'(merged);
    end
  end

endmodule

`default_nettype wire

/* source/multi_xfer_distributor.sv */
// Top level of the distributor with its core, arbiter and priority pointer
`default_nettype none

`include "mxd_params.svh"

module multi_xfer_distributor (
  input  logic                clk,
  input  logic                arst_n,
  input  mxd_pkg::count_t     push_sendable,
  output mxd_pkg::count_t     push_receivable,
  input  mxd_pkg::symbol_t    push_data [`NUM_SYMBOLS],
  output mxd_pkg::flow_mask_t pop_valid,
  input  mxd_pkg::flow_mask_t pop_ready,
  output mxd_pkg::symbol_t    pop_data [`NUM_FLOWS]
);

  // Arbiter requests and lane limit from the core
  mxd_pkg::flow_mask_t request;
  mxd_pkg::count_t     grant_allowed;

  // Arbiter results shared by the core and the pointer
  mxd_pkg::flow_mask_t grant;
  mxd_pkg::flow_mask_t grant_ordered [`NUM_SYMBOLS];
  mxd_pkg::count_t     grant_count;

  // Round-robin starting flow, the only state in the design
  mxd_pkg::flow_idx_t  priority_idx;

  multi_xfer_distributor_core #(
    .symbol_type(mxd_pkg::symbol_t)
  ) i_core (
    .push_sendable  (push_sendable),
    .push_receivable(push_receivable),
    .push_data      (push_data),
    .pop_valid      (pop_valid),
    .pop_ready      (pop_ready),
    .pop_data       (pop_data),
    .request        (request),
    .grant_allowed  (grant_allowed),
    .grant          (grant),
    .grant_ordered  (grant_ordered),
    .grant_count    (grant_count)
  );

  multi_grant_arbiter i_arbiter (
    .request      (request),
    .grant_allowed(grant_allowed),
    .priority_idx (priority_idx),
    .grant        (grant),
    .grant_ordered(grant_ordered),
    .grant_count  (grant_count)
  );

  // Takes effect one cycle after the grant that moves it
  rr_priority_pointer i_pointer (
    .clk         (clk),
    .arst_n      (arst_n),
    .grant       (grant),
    .grant_count (grant_count),
    .priority_idx(priority_idx)
  );

endmodule

`default_nettype wire

/* sim/multi_xfer_distributor_assertions.sv */
// Concurrent checks on push counts and pop valids, bound to the distributor top level
`default_nettype none

`include "mxd_params.svh"

module multi_xfer_distributor_assertions (
  input logic                clk,
  input logic                arst_n,
  input mxd_pkg::count_t     push_sendable,
  input mxd_pkg::count_t     push_receivable,
  input mxd_pkg::flow_mask_t pop_valid,
  input mxd_pkg::flow_mask_t pop_ready
);
  timeunit 1ns;
  timeprecision 100ps;

  // Failed assertions, read by the testbench at the end of the run
  int assert_failures = 0;

  // The source can never lose more symbols than it offered
  receivable_bounded: assert property (
    @(posedge clk) disable iff (!arst_n) push_receivable <= push_sendable
  ) else begin
    $error("push_receivable 0x%0h exceeds push_sendable 0x%0h", push_receivable, push_sendable);
    assert_failures++;
  end

  // Every consumed lane lands in exactly one flow
  valid_count_matches: assert property (
    @(posedge clk) disable iff (!arst_n) $countones(pop_valid) == int'(push_receivable)
  ) else begin
    $error("pop_valid 0x%0h does not match push_receivable 0x%0h", pop_valid, push_receivable);
    assert_failures++;
  end

  // A flow only sees valid when it is ready
  valid_within_ready: assert property (
    @(posedge clk) disable iff (!arst_n) (pop_valid & ~pop_ready) == '0
  ) else begin
    $error("pop_valid 0x%0h outside pop_ready 0x%0h", pop_valid, pop_ready);
    assert_failures++;
  end

endmodule

bind multi_xfer_distributor multi_xfer_distributor_assertions i_assertions (
  .clk            (clk),
  .arst_n         (arst_n),
  .push_sendable  (push_sendable),
  .push_receivable(push_receivable),
  .pop_valid      (pop_valid),
  .pop_ready      (pop_ready)
);

`default_nettype wire

/* sim/multi_xfer_distributor_tb.sv */
// Testbench with directed tests, a reference model, LFSR stimulus and compare tasks
`default_nettype none

`include "mxd_params.svh"

module multi_xfer_distributor_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int reset_timeout = 20;
  localparam int random_cycles = 200;

  logic                clk;
  logic                arst_n;
  mxd_pkg::count_t     push_sendable;
  mxd_pkg::count_t     push_receivable;
  mxd_pkg::symbol_t    push_data [`NUM_SYMBOLS];
  mxd_pkg::flow_mask_t pop_valid;
  mxd_pkg::flow_mask_t pop_ready;
  mxd_pkg::symbol_t    pop_data [`NUM_FLOWS];

  // Reference model state and its predictions for the current cycle
  mxd_pkg::flow_idx_t  model_priority;
  mxd_pkg::flow_idx_t  exp_next;
  mxd_pkg::flow_mask_t exp_valid;
  mxd_pkg::count_t     exp_count;
  mxd_pkg::symbol_t    exp_data [`NUM_FLOWS];

  // 17-bit Fibonacci LFSR with taps 17 and 14
  logic [16:0] lfsr_state;

  logic reset_released;

  int mask_errors;
  int count_errors;
  int symbol_errors;
  int assert_errors;

  multi_xfer_distributor i_multi_xfer_distributor (
    .clk            (clk),
    .arst_n         (arst_n),
    .push_sendable  (push_sendable),
    .push_receivable(push_receivable),
    .push_data      (push_data),
    .pop_valid      (pop_valid),
    .pop_ready      (pop_ready),
    .pop_data       (pop_data)
  );

  always #2 clk = ~clk;

  // Reset is held over the first four rising edges
  initial begin
    arst_n = 1'b0;
    repeat (4) @(posedge clk);
    #1;
    arst_n = 1'b1;
  end

  function automatic logic lfsr_bit();
    logic fb;
    fb = lfsr_state[16] ^ lfsr_state[13];
    lfsr_state = {lfsr_state[15:0], fb};
    return fb;
  endfunction

  // One LFSR step per bit taken
  function automatic logic [31:0] random_bits(input int width);
    logic [31:0] value;
    value = '0;
    for (int b = 0; b < width; b++) begin
      value = {value[30:0], lfsr_bit()};
    end
    return value;
  endfunction

  task automatic check_mask(input string name, input mxd_pkg::flow_mask_t actual,
                            input mxd_pkg::flow_mask_t expected);
    if (actual !== expected) begin
      mask_errors++;
      $display("FAIL %s: got 0x%0h, expected 0x%0h at %0t", name, actual, expected, $time);
    end
  endtask

  task automatic check_count(input string name, input mxd_pkg::count_t actual,
                             input mxd_pkg::count_t expected);
    if (actual !== expected) begin
      count_errors++;
      $display("FAIL %s: got 0x%0h, expected 0x%0h at %0t", name, actual, expected, $time);
    end
  endtask

  task automatic check_symbol(input string name, input mxd_pkg::symbol_t actual,
                              input mxd_pkg::symbol_t expected);
    if (actual !== expected) begin
      symbol_errors++;
      $display("FAIL %s: got 0x%0h, expected 0x%0h at %0t", name, actual, expected, $time);
    end
  endtask

  // Ready flows take lanes in scan order from the model priority
  // until the offered symbols run out
  function automatic void predict_outputs();
    int filled;
    int flow;
    filled = 0;
    exp_valid = '0;
    exp_next = model_priority;
    for (int i = 0; i < `NUM_FLOWS; i++) begin
      exp_data[i] = '0;
    end
    for (int k = 0; k < `NUM_FLOWS; k++) begin
      flow = (int'(model_priority) + k) % `NUM_FLOWS;
      if (pop_ready[flow] && filled < int'(push_sendable)) begin
        exp_valid[flow] = 1'b1;
        exp_data[flow] = push_data[filled];
        filled++;
        exp_next = mxd_pkg::flow_idx_t'((flow + 1) % `NUM_FLOWS);
      end
    end
    exp_count = mxd_pkg::count_t'(filled);
  endfunction

  task automatic load_lanes();
    for (int j = 0; j < `NUM_SYMBOLS; j++) begin
      push_data[j] = mxd_pkg::symbol_t'(random_bits(`SYMBOL_WIDTH));
    end
  endtask

  // Called 1 ns after an edge and compares the outputs 1 ns before the next edge
  task automatic drive_and_check(input mxd_pkg::flow_mask_t ready,
                                 input mxd_pkg::count_t sendable);
    pop_ready = ready;
    push_sendable = sendable;
    predict_outputs();
    #2;
    check_mask("pop_valid", pop_valid, exp_valid);
    check_count("push_receivable", push_receivable, exp_count);
    for (int i = 0; i < `NUM_FLOWS; i++) begin
      check_symbol($sformatf("pop_data[%0d]", i), pop_data[i], exp_data[i]);
    end
  endtask

  // The model pointer moves at the same edge as the DUT pointer
  task automatic next_cycle();
    @(posedge clk);
    if (exp_count != '0) begin
      model_priority = exp_next;
    end
    #1;
  endtask

  // Returns 1 ns after the first rising edge with reset released
  task automatic wait_reset_release(output logic released);
    int cycles;
    cycles = 0;
    while ((arst_n !== 1'b1) && (cycles < reset_timeout)) begin
      @(posedge clk);
      cycles++;
    end
    released = (arst_n === 1'b1);
    if (!released) begin
      $display("Timeout: reset still asserted after %0d cycles", reset_timeout);
    end
    #1;
  endtask

  task automatic test_reset_idle();
    load_lanes();
    drive_and_check('1, '0);
    check_mask("pop_valid", pop_valid, '0);
    check_count("push_receivable", push_receivable, '0);
    next_cycle();
    // Symbols on offer but nobody to take them
    drive_and_check('0, mxd_pkg::count_t'(`NUM_SYMBOLS));
    check_count("push_receivable", push_receivable, '0);
    next_cycle();
  endtask

  task automatic test_full_rotation();
    mxd_pkg::flow_mask_t expected;
    int start;
    int flow;
    for (int c = 0; c < 4; c++) begin
      start = (c * `NUM_SYMBOLS) % `NUM_FLOWS;
      expected = '0;
      load_lanes();
      drive_and_check('1, mxd_pkg::count_t'(`NUM_SYMBOLS));
      for (int j = 0; j < `NUM_SYMBOLS; j++) begin
        flow = (start + j) % `NUM_FLOWS;
        expected[flow] = 1'b1;
        check_symbol($sformatf("pop_data[%0d]", flow), pop_data[flow], push_data[j]);
      end
      check_mask("pop_valid", pop_valid, expected);
      next_cycle();
    end
  endtask

  task automatic test_partial_ready();
    int ready_flow;
    ready_flow = `NUM_FLOWS / 2;
    load_lanes();
    drive_and_check(mxd_pkg::flow_mask_t'(1) << ready_flow, mxd_pkg::count_t'(`NUM_SYMBOLS));
    check_count("push_receivable", push_receivable, mxd_pkg::count_t'(1));
    check_symbol($sformatf("pop_data[%0d]", ready_flow), pop_data[ready_flow], push_data[0]);
    next_cycle();
    // The next scan starts right after the flow that was served
    load_lanes();
    drive_and_check('1, mxd_pkg::count_t'(1));
    check_mask("pop_valid", pop_valid,
               mxd_pkg::flow_mask_t'(1) << ((ready_flow + 1) % `NUM_FLOWS));
    next_cycle();
  endtask

  task automatic test_single_symbol();
    for (int c = 0; c < `NUM_FLOWS; c++) begin
      load_lanes();
      drive_and_check('1, mxd_pkg::count_t'(1));
      check_mask("pop_valid", pop_valid, mxd_pkg::flow_mask_t'(1) << c);
      check_symbol($sformatf("pop_data[%0d]", c), pop_data[c], push_data[0]);
      next_cycle();
    end
  endtask

  task automatic test_random_traffic();
    mxd_pkg::symbol_t pending [`NUM_SYMBOLS];
    mxd_pkg::flow_mask_t ready;
    mxd_pkg::count_t sendable;
    int taken;
    for (int j = 0; j < `NUM_SYMBOLS; j++) begin
      pending[j] = mxd_pkg::symbol_t'(random_bits(`SYMBOL_WIDTH));
    end
    for (int c = 0; c < random_cycles; c++) begin
      push_data = pending;
      ready = mxd_pkg::flow_mask_t'(random_bits(`NUM_FLOWS));
      sendable = mxd_pkg::count_t'(random_bits($bits(mxd_pkg::count_t)) % (`NUM_SYMBOLS + 1));
      drive_and_check(ready, sendable);
      // Accepted lanes leave the source and the rest move down to lane 0 onward
      taken = int'(exp_count);
      for (int j = 0; j < `NUM_SYMBOLS; j++) begin
        if (j + taken < `NUM_SYMBOLS) begin
          pending[j] = pending[j + taken];
        end else begin
          pending[j] = mxd_pkg::symbol_t'(random_bits(`SYMBOL_WIDTH));
        end
      end
      next_cycle();
    end
  endtask

  initial begin
    clk = 1'b0;
    push_sendable = '0;
    pop_ready = '0;
    for (int j = 0; j < `NUM_SYMBOLS; j++) begin
      push_data[j] = '0;
    end
    lfsr_state = 17'd99084;
    model_priority = '0;
    exp_count = '0;
    mask_errors = 0;
    count_errors = 0;
    symbol_errors = 0;

    wait_reset_release(reset_released);
    if (!reset_released) begin
      $display("STATUS: FAIL");
      $finish;
    end else begin
      test_reset_idle();
      test_full_rotation();
      test_partial_ready();
      test_single_symbol();
      test_random_traffic();

      assert_errors = i_multi_xfer_distributor.i_assertions.assert_failures;
      $display("Errors: %0d mask, %0d count, %0d symbol, %0d assertion",
               mask_errors, count_errors, symbol_errors, assert_errors);
      if (mask_errors + count_errors + symbol_errors + assert_errors == 0) begin
        $display("STATUS: PASS");
      end else begin
        $display("STATUS: FAIL");
      end
      $finish;
    end
  end

endmodule

`default_nettype wire

/* list.f */
+incdir+source
source/mxd_pkg.sv
source/rr_priority_pointer.sv
source/multi_grant_arbiter.sv
source/multi_xfer_distributor_core.sv
source/multi_xfer_distributor.sv
sim/multi_xfer_distributor_assertions.sv
sim/multi_xfer_distributor_tb.sv

/* Makefile */
TOP := multi_xfer_distributor_tb
LOG := sim.log

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/100ps -j 0 -f list.f --top-module $(TOP)
	-./obj_dir/V$(TOP) +verilator+error+limit+1000 > $(LOG) 2>&1
	cat $(LOG)
	! grep -q "STATUS: FAIL" $(LOG)
	grep -q "STATUS: PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
